//--- logic/dvbs2_pkg.sv
`default_nettype none

package dvbs2_pkg;

	// one transport stream byte
	typedef logic [7:0] ts_byte_t;

	// one symbol component, signed Q2.13
	typedef logic signed [15:0] sym_t;

	// symbol as a pair of components, re in the upper half
	typedef struct packed {
		sym_t re;
		sym_t im;
	} iq_pair_t;

	// same 32 bits, either as one word or as the re/im pair
	typedef union packed {
		logic [31:0] raw;
		iq_pair_t iq;
	} iq_word_u;

	// 0.7071 in Q2.13
	// negated value is 16'hE960
	localparam sym_t QPSK_AMP = 16'sh16A0;

	// x^8 + x^7 + x^6 + x^4 + x^2 + 1
	// msb first, register starts at zero, no final inversion
	localparam ts_byte_t CRC8_POLY = 8'hD5;

	// bb scrambler seed 100101010000000
	// first stage of the sequence sits in bit 0
	// feedback is stage 14 xor stage 15, i.e. 1 + x^14 + x^15
	localparam logic [14:0] PRBS_INIT = 15'h00A9;

endpackage

`default_nettype wire

//--- logic/ts_crc8_insert.sv
`timescale 1ns/1ns
`default_nettype none

module ts_crc8_insert (
	input wire mpeg_clk,
	input wire rst_n,
	input wire dvbs2_pkg::ts_byte_t mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,
	output dvbs2_pkg::ts_byte_t crc_byte,
	output logic crc_valid
);

	// running crc over the payload of the current packet
	dvbs2_pkg::ts_byte_t crc_reg;
	dvbs2_pkg::ts_byte_t crc_next;

	// fold one byte into the crc, msb first
	function automatic dvbs2_pkg::ts_byte_t crc8_byte(
		dvbs2_pkg::ts_byte_t crc,
		dvbs2_pkg::ts_byte_t data
	);
		dvbs2_pkg::ts_byte_t c;
		logic fb;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			// feedback from top stage and incoming bit
			fb = c[7] ^ data[i];
			c = {c[6:0], 1'b0};
			if (fb) begin
				c = c ^ dvbs2_pkg::CRC8_POLY;
			end
		end
		return c;
	endfunction

	assign crc_next = crc8_byte(crc_reg, mpeg_data);

	// control side, valid and crc state
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			crc_valid <= 1'b0;
			crc_reg <= '0;
		end else begin
			// one cycle latency, same edge as the prbs byte
			crc_valid <= mpeg_valid;
			if (mpeg_valid) begin
				if (mpeg_sync) begin
					// previous packet is done
					// start fresh for the new payload
					crc_reg <= '0;
				end else begin
					crc_reg <= crc_next;
				end
			end
		end
	end

	// outgoing byte
	// sync position carries the crc of the packet before it
	// so the first packet after reset shows 8'h00 there
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			if (mpeg_sync) begin
				crc_byte <= crc_reg;
			end else begin
				// payload passes straight through
				crc_byte <= mpeg_data;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/bb_prbs_gen.sv
`timescale 1ns/1ns
`default_nettype none

module bb_prbs_gen #(
	parameter int FRAME_PACKETS = 8
) (
	input wire mpeg_clk,
	input wire rst_n,
	input wire mpeg_valid,
	input wire mpeg_sync,
	output dvbs2_pkg::ts_byte_t prbs_byte
);

	// counter needs at least one bit even for a single packet frame
	localparam int CNT_W = (FRAME_PACKETS > 1) ? $clog2(FRAME_PACKETS) : 1;

	logic [14:0] lfsr;
	logic [CNT_W-1:0] pkt_cnt;
	logic frame_start;
	logic [14:0] prbs_seed;
	logic [14:0] prbs_next;
	dvbs2_pkg::ts_byte_t prbs_bits;

	// eight scrambler steps in one go
	// returns next state in the top 15 bits, output byte below
	function automatic logic [22:0] prbs_step8(logic [14:0] seed);
		logic [14:0] r;
		logic [7:0] bits;
		logic fb;
		r = seed;
		bits = '0;
		for (int i = 7; i >= 0; i--) begin
			// stage 14 xor stage 15
			fb = r[13] ^ r[14];
			// first bit out lands in bit 7
			bits[i] = fb;
			r = {r[13:0], fb};
		end
		return {r, bits};
	endfunction

	// sync of packet 0 in the frame reloads the sequence
	assign frame_start = mpeg_sync && (pkt_cnt == '0);
	assign prbs_seed = frame_start ? dvbs2_pkg::PRBS_INIT : lfsr;
	assign {prbs_next, prbs_bits} = prbs_step8(prbs_seed);

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			lfsr <= dvbs2_pkg::PRBS_INIT;
			// zero here, so the next sync opens a frame
			pkt_cnt <= '0;
		end else if (mpeg_valid) begin
			lfsr <= prbs_next;
			if (mpeg_sync) begin
				// packets per frame, wraps at FRAME_PACKETS
				if (pkt_cnt == CNT_W'(FRAME_PACKETS - 1)) begin
					pkt_cnt <= '0;
				end else begin
					pkt_cnt <= pkt_cnt + 1'b1;
				end
			end
		end
	end

	// byte lines up with crc_valid downstream
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			prbs_byte <= prbs_bits;
		end
	end

endmodule

`default_nettype wire

//--- logic/qpsk_symbol_mapper.sv
`timescale 1ns/1ns
`default_nettype none

module qpsk_symbol_mapper (
	input wire mpeg_clk,
	input wire rst_n,
	input wire dvbs2_pkg::ts_byte_t crc_byte,
	input wire crc_valid,
	input wire dvbs2_pkg::ts_byte_t prbs_byte,
	output logic ts_clk,
	output logic symbol_oe,
	output dvbs2_pkg::sym_t symbol_re,
	output dvbs2_pkg::sym_t symbol_im
);

	// scrambled byte, straight off the two upstream registers
	dvbs2_pkg::ts_byte_t scr_byte;
	// pairs still waiting, next pair in bits 7:6
	dvbs2_pkg::ts_byte_t shift_reg;
	logic [1:0] pairs_left;
	// pacing slot, free running
	logic [1:0] slot_cnt;
	dvbs2_pkg::iq_word_u sym_word;

	// bit 0 gives +amp, bit 1 gives -amp
	// even bit of the pair drives re, odd bit drives im
	function automatic dvbs2_pkg::iq_word_u map_pair(logic [1:0] pair);
		dvbs2_pkg::iq_word_u w;
		w.iq.re = pair[0] ? -dvbs2_pkg::QPSK_AMP : dvbs2_pkg::QPSK_AMP;
		w.iq.im = pair[1] ? -dvbs2_pkg::QPSK_AMP : dvbs2_pkg::QPSK_AMP;
		return w;
	endfunction

	assign scr_byte = crc_byte ^ prbs_byte;

	// one strobe every four cycles
	// first one four edges out of reset
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			slot_cnt <= '0;
			ts_clk <= 1'b0;
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
			ts_clk <= (slot_cnt == 2'd3);
		end
	end

	// symbol sequencing
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			symbol_oe <= 1'b0;
			pairs_left <= '0;
			sym_word <= '0;
		end else if (crc_valid) begin
			// new byte, bits 7:6 go out right away
			// also cuts short any byte still in flight
			sym_word <= map_pair(scr_byte[7:6]);
			pairs_left <= 2'd3;
			symbol_oe <= 1'b1;
		end else if (pairs_left != '0) begin
			sym_word <= map_pair(shift_reg[7:6]);
			pairs_left <= pairs_left - 1'b1;
			symbol_oe <= 1'b1;
		end else begin
			// idle, last symbol value is simply held
			symbol_oe <= 1'b0;
		end
	end

	// remaining pairs, msb pair first
	always_ff @(posedge mpeg_clk) begin
		if (crc_valid) begin
			shift_reg <= {scr_byte[5:0], 2'b00};
		end else if (pairs_left != '0) begin
			shift_reg <= {shift_reg[5:0], 2'b00};
		end
	end

	// halves of the raw word
	assign symbol_re = sym_word.raw[31:16];
	assign symbol_im = sym_word.raw[15:0];

endmodule

`default_nettype wire

//--- logic/dvbs2_tx_core.sv
`timescale 1ns/1ns
`default_nettype none

module dvbs2_tx_core #(
	parameter int FRAME_PACKETS = 8
) (
	input wire mpeg_clk,
	input wire rst_n,
	// ts input, one byte per ts_clk slot
	input wire dvbs2_pkg::ts_byte_t mpeg_data,
	input wire mpeg_valid,
	// high with the first byte of each packet
	input wire mpeg_sync,
	// source pacing strobe
	output logic ts_clk,
	// qpsk symbols
	output logic symbol_oe,
	output dvbs2_pkg::sym_t symbol_re,
	output dvbs2_pkg::sym_t symbol_im
);

	// crc stage out
	dvbs2_pkg::ts_byte_t crc_byte;
	logic crc_valid;
	// scrambler byte, same cycle as crc_valid
	dvbs2_pkg::ts_byte_t prbs_byte;

	// sync byte replaced by crc of previous packet
	ts_crc8_insert u_crc8 (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.crc_byte(crc_byte),
		.crc_valid(crc_valid)
	);

	// bb scrambling bits, reloaded every FRAME_PACKETS packets
	bb_prbs_gen #(
		.FRAME_PACKETS(FRAME_PACKETS)
	) u_prbs (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.prbs_byte(prbs_byte)
	);

	// xor, bit pairs to symbols, and ts_clk pacing
	qpsk_symbol_mapper u_mapper (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.crc_byte(crc_byte),
		.crc_valid(crc_valid),
		.prbs_byte(prbs_byte),
		.ts_clk(ts_clk),
		.symbol_oe(symbol_oe),
		.symbol_re(symbol_re),
		.symbol_im(symbol_im)
	);

endmodule

`default_nettype wire

//--- tests/dvbs2_tx_sva.sv
`timescale 1ns/1ns
`default_nettype none

module dvbs2_tx_sva (
	input wire mpeg_clk,
	input wire rst_n,
	input wire ts_clk,
	input wire symbol_oe,
	input wire dvbs2_pkg::sym_t symbol_re,
	input wire dvbs2_pkg::sym_t symbol_im
);

	// the two qpsk levels
	localparam dvbs2_pkg::sym_t POS = dvbs2_pkg::QPSK_AMP;
	localparam dvbs2_pkg::sym_t NEG = -dvbs2_pkg::QPSK_AMP;

	// both components on the grid while symbols are out
	a_on_grid: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		symbol_oe |-> ((symbol_re == POS) || (symbol_re == NEG)) &&
			((symbol_im == POS) || (symbol_im == NEG)))
		else $error("symbol component off the qpsk grid");

	// at most one strobe in any four cycles
	a_ts_clk_spacing: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		ts_clk |-> !$past(ts_clk, 1) && !$past(ts_clk, 2) && !$past(ts_clk, 3))
		else $error("ts_clk strobes closer than four cycles");

	// sync reset, so oe drops one edge after rst_n is seen low
	a_oe_in_reset: assert property (@(posedge mpeg_clk) !rst_n |=> !symbol_oe)
		else $error("symbol_oe high during reset");

endmodule

bind dvbs2_tx_core dvbs2_tx_sva u_sva (
	.mpeg_clk(mpeg_clk),
	.rst_n(rst_n),
	.ts_clk(ts_clk),
	.symbol_oe(symbol_oe),
	.symbol_re(symbol_re),
	.symbol_im(symbol_im)
);

`default_nettype wire

//--- include/tb_dvbs2_model.svh
`ifndef TB_DVBS2_MODEL_SVH
`define TB_DVBS2_MODEL_SVH

// crc-8 update for one byte, msb first, no final inversion
// byte xored into the register then eight shifts
function automatic logic [7:0] crc8_update(logic [7:0] crc, logic [7:0] data);
	logic [7:0] c;
	c = crc ^ data;
	for (int i = 0; i < 8; i++) begin
		if (c[7]) begin
			c = {c[6:0], 1'b0} ^ dvbs2_pkg::CRC8_POLY;
		end else begin
			c = {c[6:0], 1'b0};
		end
	end
	return c;
endfunction

// scrambler output bit for the current state
function automatic logic prbs_out_bit(logic [14:0] r);
	return r[13] ^ r[14];
endfunction

// state after one scrambler step
function automatic logic [14:0] prbs_advance(logic [14:0] r);
	return {r[13:0], prbs_out_bit(r)};
endfunction

// one symbol from a bit pair
// even bit to re, odd bit to im, a set bit is the negative level
function automatic dvbs2_pkg::iq_word_u qpsk_point(logic [1:0] pair);
	dvbs2_pkg::iq_word_u w;
	w.iq.re = pair[0] ? -dvbs2_pkg::QPSK_AMP : dvbs2_pkg::QPSK_AMP;
	w.iq.im = pair[1] ? -dvbs2_pkg::QPSK_AMP : dvbs2_pkg::QPSK_AMP;
	return w;
endfunction

`endif

//--- tests/tb_dvbs2_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dvbs2_tx;

	`include "tb_dvbs2_model.svh"

	// short frames keep the reload visible
	localparam int FRAMES = 2;
	localparam int PKT_LEN = 188;
	localparam logic [7:0] SYNC_BYTE = 8'h47;
	localparam int N_ENTRIES = 5;
	localparam int SYMS_PER_PKT = PKT_LEN * 4;
	// payload kinds
	localparam int COUNTING = 0;
	localparam int ZEROS = 1;
	localparam int RANDOM = 2;

	typedef struct packed {
		int pkts;
		int kind;
		int idle;
		logic rst;
	} entry_t;

	logic mpeg_clk;
	logic rst_n;
	dvbs2_pkg::ts_byte_t mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic ts_clk;
	logic symbol_oe;
	dvbs2_pkg::sym_t symbol_re;
	dvbs2_pkg::sym_t symbol_im;

	entry_t tbl [N_ENTRIES];
	// expected symbols and the edge each one is due after
	dvbs2_pkg::iq_word_u exp_q[$];
	int due_q[$];
	// predicted symbols of the current entry in order
	dvbs2_pkg::iq_word_u pred_q[$];
	dvbs2_pkg::iq_word_u obs_q[$];
	logic [31:0] lcg_state;
	// reference state
	logic [7:0] m_crc;
	logic [14:0] m_lfsr;
	int m_pkt;
	int edge_cnt = 0;
	int low_edges = 0;
	int rel_edges = 0;
	int last_strobe = 0;
	logic strobe_seen = 1'b0;
	int limit = 1000000;
	int sym_errs = 0;
	int cnt_errs = 0;
	int misc_errs = 0;

	dvbs2_tx_core #(
		.FRAME_PACKETS(FRAMES)
	) UUT (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.ts_clk(ts_clk),
		.symbol_oe(symbol_oe),
		.symbol_re(symbol_re),
		.symbol_im(symbol_im)
	);

	initial begin
		mpeg_clk = 1'b0;
		forever #2 mpeg_clk = ~mpeg_clk;
	end

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	task automatic check_symbol(input string name, input dvbs2_pkg::iq_word_u exp,
		input dvbs2_pkg::iq_word_u act);
		if (exp.raw !== act.raw) begin
			$display("Fail %0t ns: %s expected re=%h im=%h, got re=%h im=%h", $time, name,
				exp.iq.re, exp.iq.im, act.iq.re, act.iq.im);
			sym_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Fail %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
			cnt_errs++;
		end
	endtask

	// mirror of crc, scrambler and frame count for one byte
	task automatic predict_byte(input logic [7:0] data, input logic sync);
		logic [7:0] sub;
		logic [7:0] pb;
		logic [7:0] x;
		if (sync) begin
			sub = m_crc;
			m_crc = 8'h00;
		end else begin
			sub = data;
			m_crc = crc8_update(m_crc, data);
		end
		if (sync && m_pkt == 0) begin
			m_lfsr = dvbs2_pkg::PRBS_INIT;
		end
		for (int i = 7; i >= 0; i--) begin
			pb[i] = prbs_out_bit(m_lfsr);
			m_lfsr = prbs_advance(m_lfsr);
		end
		if (sync) begin
			m_pkt = (m_pkt + 1) % FRAMES;
		end
		x = sub ^ pb;
		// sampled at the next edge and first symbol one edge later
		for (int j = 0; j < 4; j++) begin
			exp_q.push_back(qpsk_point(x[7 - 2 * j -: 2]));
			pred_q.push_back(qpsk_point(x[7 - 2 * j -: 2]));
			due_q.push_back(edge_cnt + 2 + j);
		end
	endtask

	task automatic apply_reset();
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		rst_n = 1'b0;
		@(posedge mpeg_clk);
		#1;
		// in-flight symbols die with the reset
		exp_q.delete();
		due_q.delete();
		m_crc = 8'h00;
		m_lfsr = dvbs2_pkg::PRBS_INIT;
		m_pkt = 0;
		repeat (3) @(posedge mpeg_clk);
		#1;
		rst_n = 1'b1;
	endtask

	// skip idle slots then send one byte in the slot after ts_clk
	task automatic send_byte(input logic [7:0] data, input logic sync, input int idle);
		repeat (idle + 1) begin
			@(posedge mpeg_clk);
			#1;
			while (!ts_clk) begin
				@(posedge mpeg_clk);
				#1;
			end
		end
		@(posedge mpeg_clk);
		#1;
		mpeg_data = data;
		mpeg_sync = sync;
		mpeg_valid = 1'b1;
		predict_byte(data, sync);
		@(posedge mpeg_clk);
		#1;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mpeg_data = 8'h00;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge mpeg_clk);
		end
		@(posedge mpeg_clk);
		#1;
		check_count("symbol_oe after drain", 0, int'(symbol_oe));
	endtask

	// packet 2 of a zero entry must repeat the predicted packet 0
	task automatic compare_frames(input int pkts);
		check_count("symbols in zero entry", pkts * SYMS_PER_PKT, obs_q.size());
		if (obs_q.size() >= 3 * SYMS_PER_PKT && pred_q.size() >= SYMS_PER_PKT) begin
			for (int i = 0; i < SYMS_PER_PKT; i++) begin
				check_symbol("packet 2 symbol", pred_q[i], obs_q[2 * SYMS_PER_PKT + i]);
			end
		end
	endtask

	// edge counters and run limit
	always @(posedge mpeg_clk) begin
		edge_cnt++;
		if (!rst_n) begin
			low_edges++;
			rel_edges = 0;
		end else begin
			low_edges = 0;
			rel_edges++;
		end
		if (edge_cnt > limit) begin
			$display("Timeout after %0d cycles, the symbol stream never finished", edge_cnt);
			$display("errors: symbol %0d, count %0d, other %0d", sym_errs, cnt_errs, misc_errs);
			$display("Regression failed");
			$finish;
		end
	end

	// monitor samples mid-cycle
	always @(negedge mpeg_clk) begin : monitor
		dvbs2_pkg::iq_word_u act;
		act.iq.re = symbol_re;
		act.iq.im = symbol_im;
		// reset window lasts until the first ts_clk after release
		if ((!rst_n && low_edges >= 1) || (rst_n && rel_edges < 4)) begin
			check_count("symbol_oe around reset", 0, int'(symbol_oe));
			check_count("ts_clk around reset", 0, int'(ts_clk));
			check_symbol("symbol around reset", '0, act);
			strobe_seen = 1'b0;
		end else if (symbol_oe) begin
			if (exp_q.size() == 0) begin
				$display("symbol_oe high at %0t ns with no symbol expected", $time);
				misc_errs++;
			end else begin
				check_symbol("symbol", exp_q.pop_front(), act);
				check_count("symbol edge", due_q.pop_front(), edge_cnt);
				obs_q.push_back(act);
			end
		end
		if (rst_n && ts_clk) begin
			if (!strobe_seen) begin
				check_count("first ts_clk edge", 4, rel_edges);
			end else begin
				check_count("ts_clk period", 4, edge_cnt - last_strobe);
			end
			strobe_seen = 1'b1;
			last_strobe = edge_cnt;
		end
	end

	initial begin : stimulus
		int n_bytes;
		int max_idle;
		logic [7:0] b;
		mpeg_data = 8'h00;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		rst_n = 1'b0;
		lcg_state = 32'hbd51_01c8;
		// packets, payload, idle slots, reset before
		tbl[0] = '{2, COUNTING, 0, 1'b0};
		tbl[1] = '{3, ZEROS, 0, 1'b1};
		tbl[2] = '{2, RANDOM, 1, 1'b0};
		tbl[3] = '{1, RANDOM, 0, 1'b1};
		tbl[4] = '{2, COUNTING, 2, 1'b0};
		n_bytes = 0;
		max_idle = 0;
		foreach (tbl[i]) begin
			n_bytes += tbl[i].pkts * PKT_LEN;
			if (tbl[i].idle > max_idle) begin
				max_idle = tbl[i].idle;
			end
		end
		limit = n_bytes * 4 * (1 + max_idle) + 200;
		apply_reset();
		for (int e = 0; e < N_ENTRIES; e++) begin
			// reset lands while the last byte is still in flight
			if (tbl[e].rst) begin
				apply_reset();
			end
			obs_q.delete();
			pred_q.delete();
			for (int p = 0; p < tbl[e].pkts; p++) begin
				send_byte(SYNC_BYTE, 1'b1, tbl[e].idle);
				for (int i = 1; i < PKT_LEN; i++) begin
					case (tbl[e].kind)
						COUNTING: b = 8'(i + 7 * p);
						ZEROS: b = 8'h00;
						default: b = lcg_byte();
					endcase
					send_byte(b, 1'b0, tbl[e].idle);
				end
			end
			if (e == N_ENTRIES - 1 || !tbl[e + 1].rst) begin
				wait_drain();
			end
			if (tbl[e].kind == ZEROS && tbl[e].pkts >= 3) begin
				compare_frames(tbl[e].pkts);
			end
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected symbols never came out", exp_q.size());
			misc_errs++;
		end
		$display("errors: symbol %0d, count %0d, other %0d", sym_errs, cnt_errs, misc_errs);
		if (sym_errs + cnt_errs + misc_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/dvbs2_pkg.sv
logic/ts_crc8_insert.sv
logic/bb_prbs_gen.sv
logic/qpsk_symbol_mapper.sv
logic/dvbs2_tx_core.sv
tests/dvbs2_tx_sva.sv
tests/tb_dvbs2_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, and grep the log for the verdict
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dvbs2_tx -f filelist.f -o tb_dvbs2_tx
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_dvbs2_tx > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" "$log"; then
	exit 0
fi
exit 1
